//--- Makefile
# Verilator build and run of the burst splitter testbench
TOP := tb_burst_split
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- list.f
rtl/burst_split_pkg.sv
rtl/slot_bus_if.sv
rtl/ar_splitter.sv
rtl/burst_slot.sv
rtl/r_last_gen.sv
rtl/burst_split_top.sv
test/axi_slave_model.sv
test/tb_burst_split.sv

//--- rtl/ar_splitter.sv
// AR splitter
// Accepts an AXI4 read burst, claims a slot and issues it as single-beat ARs
module ar_splitter
  import burst_split_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Upstream AR burst
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  id_t       ar_id_i,
  input  addr_t     ar_addr_i,
  input  len_t      ar_len_i,
  input  size_t     ar_size_i,
  input  burst_t    ar_burst_i,
  // Downstream single-beat AR
  output logic      m_ar_valid_o,
  input  logic      m_ar_ready_i,
  output id_t       m_ar_id_o,
  output addr_t     m_ar_addr_o,
  output size_t     m_ar_size_o,
  output burst_t    m_ar_burst_o,
  // Slot ring, allocation side
  slot_bus_if.alloc slot_bus
);

  // INIT holds ready low for the first cycle out of reset
  typedef enum logic [1:0] {
    ST_INIT,
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t    state_q;
  slot_idx_t wr_ptr_q;
  beat_cnt_t remain_q;

  // Held copy of the accepted burst
  id_t       id_q;
  addr_t     addr_q;
  size_t     size_q;
  burst_t    burst_q;

  logic      ar_hs;
  logic      m_ar_hs;

  // --------------------------------------------------
  // Handshakes
  // --------------------------------------------------
  // Only take a new burst when idle and the next slot has drained
  assign ar_ready_o = (state_q == ST_IDLE) && !slot_bus.busy[wr_ptr_q];
  assign ar_hs      = ar_valid_i && ar_ready_o;

  // Downstream AR comes straight from the held registers,
  // so it stays steady under back-pressure
  assign m_ar_valid_o = (state_q == ST_BUSY);
  assign m_ar_hs      = m_ar_valid_o && m_ar_ready_i;
  assign m_ar_id_o    = id_q;
  assign m_ar_addr_o  = addr_q;
  assign m_ar_size_o  = size_q;
  assign m_ar_burst_o = burst_q;

  // --------------------------------------------------
  // Slot allocation
  // --------------------------------------------------
  // Count is len+1 beats; widened first so len=255 gives 256
  assign slot_bus.load_cnt = beat_cnt_t'(ar_len_i) + beat_cnt_t'(1);

  always_comb begin
    slot_bus.load           = '0;
    slot_bus.load[wr_ptr_q] = ar_hs;
  end

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_INIT;
      wr_ptr_q <= '0;
      remain_q <= '0;
    end else begin
      case (state_q)
        ST_INIT: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (ar_hs) begin
            state_q  <= ST_BUSY;
            remain_q <= slot_bus.load_cnt;
            wr_ptr_q <= next_slot(wr_ptr_q);
          end
        end
        ST_BUSY: begin
          if (m_ar_hs) begin
            remain_q <= remain_q - beat_cnt_t'(1);
            // Last single-beat AR of this burst went out
            if (remain_q == beat_cnt_t'(1)) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: begin
          state_q <= ST_INIT;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // AR payload
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q    <= ar_id_i;
      addr_q  <= ar_addr_i;
      size_q  <= ar_size_i;
      burst_q <= ar_burst_i;
    end else if (m_ar_hs && (burst_q == BURST_INCR)) begin
      // INCR steps by the beat size, FIXED repeats the address
      addr_q <= addr_q + (addr_t'(1) << size_q);
    end
  end

endmodule

//--- rtl/burst_slot.sv
// Burst slot
// Beat counter for one outstanding read burst in the slot ring
module burst_slot
  import burst_split_pkg::*;
#(
  // Position of this slot in the ring
  parameter int unsigned SLOT_IDX = 0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  slot_bus_if.slot slot_bus
);

  beat_cnt_t cnt_q;
  logic      load;
  logic      dec;

  // Own strobes out of the shared one-hot vectors
  assign load = slot_bus.load[SLOT_IDX];
  assign dec  = slot_bus.dec[SLOT_IDX];

  // --------------------------------------------------
  // Remaining-beat counter
  // --------------------------------------------------
  // Load only hits a free slot and dec only a busy one,
  // so the two never meet
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= slot_bus.load_cnt;
    end else if (dec) begin
      cnt_q <= cnt_q - beat_cnt_t'(1);
    end
  end

  // Status straight from the registered count
  assign slot_bus.busy[SLOT_IDX]      = (cnt_q != '0);
  assign slot_bus.last_beat[SLOT_IDX] = (cnt_q == beat_cnt_t'(1));

endmodule

//--- rtl/burst_split_pkg.sv
// Burst splitter package
// Bus widths, AXI burst encodings, slot ring size and shared types
package burst_split_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int ID_W    = 4;
  // AXI4 len, size and burst field widths
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;

  // --------------------------------------------------
  // Slot ring
  // --------------------------------------------------
  // Bursts that may be in flight at once
  localparam int NUM_SLOTS  = 4;
  localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

  // --------------------------------------------------
  // Channel field types
  // --------------------------------------------------
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [ID_W-1:0]       id_t;
  typedef logic [LEN_W-1:0]      len_t;
  typedef logic [SIZE_W-1:0]     size_t;
  typedef logic [BURST_W-1:0]    burst_t;
  typedef logic [1:0]            resp_t;
  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;
  // One extra bit so a 256-beat burst fits
  typedef logic [LEN_W:0]        beat_cnt_t;

  // Burst type encodings (WRAP is not handled)
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  // --------------------------------------------------
  // Ring pointer helper
  // --------------------------------------------------
  // Next slot index, wraps after the last slot
  // even when NUM_SLOTS is not a power of two
  function automatic slot_idx_t next_slot(slot_idx_t idx);
    slot_idx_t nxt;
    if (idx == slot_idx_t'(NUM_SLOTS - 1)) begin
      nxt = '0;
    end else begin
      nxt = idx + slot_idx_t'(1);
    end
    return nxt;
  endfunction

endpackage

//--- rtl/burst_split_top.sv
// AXI4 read burst splitter, top level
// Splits INCR and FIXED read bursts into single-beat ARs and rebuilds R last
module burst_split_top
  import burst_split_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  // Upstream AR
  input  logic   ar_valid_i,
  output logic   ar_ready_o,
  input  id_t    ar_id_i,
  input  addr_t  ar_addr_i,
  input  len_t   ar_len_i,
  input  size_t  ar_size_i,
  input  burst_t ar_burst_i,
  // Downstream AR, len is always zero
  output logic   m_ar_valid_o,
  input  logic   m_ar_ready_i,
  output id_t    m_ar_id_o,
  output addr_t  m_ar_addr_o,
  output size_t  m_ar_size_o,
  output burst_t m_ar_burst_o,
  // Downstream R
  input  logic   m_r_valid_i,
  output logic   m_r_ready_o,
  input  id_t    m_r_id_i,
  input  data_t  m_r_data_i,
  input  resp_t  m_r_resp_i,
  // Upstream R
  output logic   r_valid_o,
  input  logic   r_ready_i,
  output id_t    r_id_o,
  output data_t  r_data_o,
  output resp_t  r_resp_o,
  output logic   r_last_o
);

  // Ring of beat counters shared by the AR and R sides
  slot_bus_if slot_bus ();

  // --------------------------------------------------
  // AR path
  // --------------------------------------------------
  ar_splitter u_ar_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_id_i      (ar_id_i),
    .ar_addr_i    (ar_addr_i),
    .ar_len_i     (ar_len_i),
    .ar_size_i    (ar_size_i),
    .ar_burst_i   (ar_burst_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o),
    .slot_bus     (slot_bus)
  );

  // --------------------------------------------------
  // Slot counters
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_slot
    burst_slot #(
      .SLOT_IDX (i)
    ) u_burst_slot (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .slot_bus (slot_bus)
    );
  end

  // --------------------------------------------------
  // R path
  // --------------------------------------------------
  r_last_gen u_r_last_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_resp_i  (m_r_resp_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .slot_bus    (slot_bus)
  );

endmodule

//--- rtl/r_last_gen.sv
// R last generator
// Forwards single-beat R responses upstream and rebuilds the burst last flag
module r_last_gen
  import burst_split_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Downstream R, one beat per split AR
  input  logic      m_r_valid_i,
  output logic      m_r_ready_o,
  input  id_t       m_r_id_i,
  input  data_t     m_r_data_i,
  input  resp_t     m_r_resp_i,
  // Upstream R with rebuilt last
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output id_t       r_id_o,
  output data_t     r_data_o,
  output resp_t     r_resp_o,
  output logic      r_last_o,
  // Slot ring, drain side
  slot_bus_if.drain slot_bus
);

  // Oldest burst still in flight
  slot_idx_t rd_ptr_q;
  logic      cur_busy;
  logic      cur_last;
  logic      r_hs;

  assign cur_busy = slot_bus.busy[rd_ptr_q];
  assign cur_last = slot_bus.last_beat[rd_ptr_q];

  // --------------------------------------------------
  // Feed-through
  // --------------------------------------------------
  // Both directions gated by the current slot, so a beat
  // is never taken before its burst has a counter
  assign r_valid_o   = m_r_valid_i && cur_busy;
  assign m_r_ready_o = r_ready_i && cur_busy;
  assign r_hs        = r_valid_o && r_ready_i;

  assign r_id_o   = m_r_id_i;
  assign r_data_o = m_r_data_i;
  assign r_resp_o = m_r_resp_i;
  // High on the single remaining beat of the burst
  assign r_last_o = cur_last;

  // --------------------------------------------------
  // Slot drain
  // --------------------------------------------------
  always_comb begin
    slot_bus.dec           = '0;
    slot_bus.dec[rd_ptr_q] = r_hs;
  end

  // Move on once the last beat has gone upstream
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
    end else if (r_hs && cur_last) begin
      rd_ptr_q <= next_slot(rd_ptr_q);
    end
  end

endmodule

//--- rtl/slot_bus_if.sv
// Slot bus
// Joins the slot allocator, the per-slot beat counters and the R drain
interface slot_bus_if
  import burst_split_pkg::*;
();

  // Allocation side: one-hot load strobe and the beat count to load
  logic [NUM_SLOTS-1:0] load;
  beat_cnt_t            load_cnt;

  // Drain side: one-hot decrement strobe for the slot at the read pointer
  logic [NUM_SLOTS-1:0] dec;

  // Slot status, one bit per slot
  // busy while beats remain, last_beat when exactly one remains
  logic [NUM_SLOTS-1:0] busy;
  logic [NUM_SLOTS-1:0] last_beat;

  // AR splitter claims free slots
  modport alloc (
    output load,
    output load_cnt,
    input  busy
  );

  // Each counter drives only its own status bit
  modport slot (
    input  load,
    input  load_cnt,
    input  dec,
    output busy,
    output last_beat
  );

  // R path walks the ring in request order
  modport drain (
    output dec,
    input  busy,
    input  last_beat
  );

endinterface

//--- test/axi_slave_model.sv
// AXI read slave model
// Answers single-beat ARs in order, R data mirrors the AR address, random stalls
module axi_slave_model
  import burst_split_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Keeps new R beats back while high
  input  logic  hold_r_i,
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  id_t   ar_id_i,
  input  addr_t ar_addr_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output id_t   r_id_o,
  output data_t r_data_o,
  output resp_t r_resp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  integer seed = 32'h5dcf;
  // ARs taken and still waiting for their R beat
  id_t    id_q[$];
  addr_t  addr_q[$];
  logic   ar_hs;
  logic   r_hs;
  logic   hold;
  logic   run;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_id_o     = '0;
    r_data_o   = '0;
    r_resp_o   = '0;
    forever begin
      // Handshakes seen here complete on the coming rising edge
      @(negedge clk_i);
      ar_hs = ar_valid_i && ar_ready_o;
      r_hs  = r_valid_o && r_ready_i;
      hold  = hold_r_i;
      run   = rst_n_i;
      if (ar_hs) begin
        id_q.push_back(ar_id_i);
        addr_q.push_back(ar_addr_i);
      end
      if (r_hs) begin
        void'(id_q.pop_front());
        void'(addr_q.pop_front());
      end
      @(posedge clk_i);
      #1;
      if (!run) begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
      end else begin
        ar_ready_o = ($random(seed) & 3) != 0;
        // A raised valid stays up until its beat is taken
        if (!r_valid_o || r_hs) begin
          r_valid_o = 1'b0;
          if ((id_q.size() != 0) && !hold && (($random(seed) & 3) != 0)) begin
            r_valid_o = 1'b1;
            r_id_o    = id_q[0];
            r_data_o  = data_t'(addr_q[0]);
            // OKAY
            r_resp_o  = 2'b00;
          end
        end
      end
    end
  end

endmodule

//--- test/tb_burst_split.sv
// Burst splitter testbench
// Random INCR and FIXED bursts with stalls on both sides, checked beat by beat
module tb_burst_split
  import burst_split_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RAND = 40;
  // 200 cycles per burst plus a margin
  localparam int WDOG_CYC = (NUM_RAND + NUM_SLOTS + 1) * 200 + 500;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } burst_rec_t;

  logic   clk_i = 1'b0;
  logic   rst_n_i;
  logic   ar_valid_i, ar_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic   m_r_valid_i, m_r_ready_o, r_valid_o, r_ready_i, r_last_o;
  id_t    ar_id_i, m_ar_id_o, m_r_id_i, r_id_o;
  addr_t  ar_addr_i, m_ar_addr_o;
  len_t   ar_len_i;
  size_t  ar_size_i, m_ar_size_o;
  burst_t ar_burst_i, m_ar_burst_o;
  data_t  m_r_data_i, r_data_o;
  resp_t  m_r_resp_i, r_resp_o;
  logic   hold_r = 1'b0;

  integer     seed = 32'h5dcf;
  string      phase = "reset";
  // Accepted bursts, one queue per direction
  burst_rec_t ar_exp_q[$];
  burst_rec_t r_exp_q[$];
  int         ar_beat = 0;
  int         r_beat = 0;

  always #10 clk_i = ~clk_i;

  burst_split_top dut0 (.*);

  axi_slave_model u_slave (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .hold_r_i   (hold_r),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_o (m_ar_ready_i),
    .ar_id_i    (m_ar_id_o),
    .ar_addr_i  (m_ar_addr_o),
    .r_valid_o  (m_r_valid_i),
    .r_ready_i  (m_r_ready_o),
    .r_id_o     (m_r_id_i),
    .r_data_o   (m_r_data_i),
    .r_resp_o   (m_r_resp_i)
  );

  // --------------------------------------------------
  // Checks and helpers
  // --------------------------------------------------
  task automatic stop_run(string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else
      stop_run($sformatf("FAILED %s %s: expected %0h, actual %0h",
                         phase, name, exp, act));
  endtask

  task automatic check_quiet(string when);
    assert (!m_ar_valid_o && !r_valid_o && !m_r_ready_o && !ar_ready_o) else
      stop_run($sformatf("Handshake outputs not low %s", when));
  endtask

  // INCR steps by 2**size bytes per beat, FIXED stays put
  function automatic addr_t beat_addr(burst_rec_t rec, int beat);
    if (rec.burst == BURST_INCR) begin
      return rec.addr + (addr_t'(beat) << rec.size);
    end
    return rec.addr;
  endfunction

  // Mostly short bursts, now and then a full 256-beat one
  function automatic burst_rec_t random_burst();
    burst_rec_t rec;
    rec.id    = id_t'($random(seed));
    rec.addr  = addr_t'($random(seed));
    rec.len   = (($random(seed) & 15) == 0) ? len_t'(255) : len_t'($random(seed) & 15);
    rec.size  = size_t'($unsigned($random(seed)) % 3);
    rec.burst = (($random(seed) & 1) != 0) ? BURST_INCR : BURST_FIXED;
    return rec;
  endfunction

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_burst(burst_rec_t rec);
    ar_valid_i = 1'b1;
    ar_id_i    = rec.id;
    ar_addr_i  = rec.addr;
    ar_len_i   = rec.len;
    ar_size_i  = rec.size;
    ar_burst_i = rec.burst;
    do @(negedge clk_i); while (!ar_ready_o);
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
  endtask

  // --------------------------------------------------
  // Monitors, sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk_i) begin
    burst_rec_t rec;
    if (rst_n_i && ar_valid_i && ar_ready_o) begin
      ar_exp_q.push_back({ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i});
      r_exp_q.push_back({ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i});
    end
    if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      assert (ar_exp_q.size() != 0) else stop_run("Downstream AR with no burst accepted");
      rec = ar_exp_q[0];
      check_value("AR id", 64'(rec.id), 64'(m_ar_id_o));
      check_value("AR size", 64'(rec.size), 64'(m_ar_size_o));
      check_value("AR burst", 64'(rec.burst), 64'(m_ar_burst_o));
      check_value("AR addr", 64'(beat_addr(rec, ar_beat)), 64'(m_ar_addr_o));
      if (ar_beat == int'(rec.len)) begin
        void'(ar_exp_q.pop_front());
        ar_beat = 0;
      end else begin
        ar_beat++;
      end
    end
    if (rst_n_i && r_valid_o && r_ready_i) begin
      assert (r_exp_q.size() != 0) else stop_run("R beat with no burst outstanding");
      rec = r_exp_q[0];
      check_value("R id", 64'(rec.id), 64'(r_id_o));
      // Slave data mirrors the downstream address of the beat
      check_value("R data", 64'(beat_addr(rec, r_beat)), 64'(r_data_o));
      check_value("R resp", 64'(2'b00), 64'(r_resp_o));
      check_value("R last", 64'(r_beat == int'(rec.len)), 64'(r_last_o));
      if (r_beat == int'(rec.len)) begin
        void'(r_exp_q.pop_front());
        r_beat = 0;
      end else begin
        r_beat++;
      end
    end
  end

  // Reset state and the first cycle after it
  initial begin
    @(negedge clk_i);
    while (!rst_n_i) begin
      check_quiet("during reset");
      @(negedge clk_i);
    end
    check_quiet("in the first cycle after reset");
  end

  // Upstream back-pressure
  initial begin
    r_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      r_ready_i = ($random(seed) & 3) != 0;
    end
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk_i);
    stop_run("Timeout, the bursts did not finish in time");
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_size_i  = '0;
    ar_burst_i = BURST_FIXED;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    phase   = "random bursts";
    for (int i = 0; i < NUM_RAND; i++) begin
      send_burst(random_burst());
    end
    do @(posedge clk_i); while (r_exp_q.size() != 0);
    #1;
    // Fill every slot with R held off, one more burst must wait
    phase  = "slot limit";
    hold_r = 1'b1;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      send_burst(random_burst());
    end
    do @(posedge clk_i); while (ar_exp_q.size() != 0);
    #1;
    fork
      send_burst(random_burst());
      begin
        repeat (10) begin
          @(negedge clk_i);
          assert (!ar_ready_o) else stop_run("ar_ready_o high with every slot in use");
        end
        @(posedge clk_i);
        #1;
        hold_r = 1'b0;
      end
    join
    do @(posedge clk_i); while (r_exp_q.size() != 0);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
